/* rtl/hp48_macros.svh */
`ifndef HP48_MACROS_SVH
`define HP48_MACROS_SVH

// a bus address is five nibbles wide on the calculator bus
`define HP48_ADDR_W 20

// number of nibbles held by the I/O RAM once it is configured
`define HP48_IO_RAM_LEN 64

// entries in the command FIFO between the sequencer and the RAM
`define HP48_FIFO_DEPTH 4

// the largest number of nibbles that one block request may move
// this also bounds the beat counter in the sequencer
`define HP48_MAX_BLOCK 4

`endif

/* rtl/hp48_bus_pkg.sv */
`include "hp48_macros.svh"

package hp48_bus_pkg;

	// command codes seen on the nibble bus
	// the numbering follows the calculator's own bus, so the gaps belong to
	// commands this device does not implement (PC write, unconfigure and the rest)
	localparam logic [3:0] BUSCMD_PC_READ   = 4'h0;
	localparam logic [3:0] BUSCMD_DP_READ   = 4'h1;
	localparam logic [3:0] BUSCMD_DP_WRITE  = 4'h3;
	localparam logic [3:0] BUSCMD_LOAD_PC   = 4'h4;
	localparam logic [3:0] BUSCMD_LOAD_DP   = 4'h5;
	localparam logic [3:0] BUSCMD_CONFIGURE = 4'h6;

	// one command word carries either a full address or a single data nibble
	// LOAD_PC, LOAD_DP and CONFIGURE read it as an address
	// DP_WRITE reads it as pad bits followed by the nibble in the low four bits
	typedef union packed {
		logic [`HP48_ADDR_W-1:0] address;
		struct packed {
			logic [`HP48_ADDR_W-5:0] pad;
			logic [3:0]              nibble;
		} data;
	} bus_payload_t;

endpackage

/* rtl/hp48_req_pkg.sv */
package hp48_req_pkg;

	// host request op codes on req_op
	// block reads and writes go through the data pointer
	localparam logic [2:0] REQ_BLOCK_READ  = 3'd0;
	localparam logic [2:0] REQ_BLOCK_WRITE = 3'd1;

	// a fetch reads nibbles through the program pointer
	localparam logic [2:0] REQ_FETCH       = 3'd2;

	// configure hands req_address to the device as its base address
	localparam logic [2:0] REQ_CONFIGURE   = 3'd3;

	// raw sends one bus command whose code is the low nibble of the address
	localparam logic [2:0] REQ_RAW         = 3'd4;

	// status returned with every read nibble on rd_status
	// a miss means the device was unconfigured or the pointer was outside its window
	localparam logic RD_MISS = 1'b0;
	localparam logic RD_HIT  = 1'b1;

endpackage

/* rtl/bus_cmd_if.sv */
// valid/ready link that carries one bus command per transfer
// a transfer happens on a strobe edge where valid and ready are both high,
// and a stalled source keeps command and payload steady until then
interface bus_cmd_if;
	import hp48_bus_pkg::*;

	logic         valid;
	logic         ready;
	logic [3:0]   command;
	bus_payload_t payload;

	// the producing side of the link
	modport source (
		output valid,
		output command,
		output payload,
		input  ready
	);

	// the consuming side of the link
	modport sink (
		input  valid,
		input  command,
		input  payload,
		output ready
	);

endinterface

/* rtl/bus_sequencer.sv */
`include "hp48_macros.svh"

// turns one host request into a short run of bus commands
// block and fetch requests load a pointer first and then issue one data beat
// per nibble, while configure and raw requests issue a single command
module bus_sequencer (
	input  logic                    strobe,
	input  logic                    rst,
	input  logic                    req_valid,
	input  logic [2:0]              req_op,
	input  logic [`HP48_ADDR_W-1:0] req_address,
	input  logic [15:0]             req_data,
	input  logic [2:0]              req_count,
	output logic                    req_ready,
	bus_cmd_if.source               link
);
	import hp48_bus_pkg::*;
	import hp48_req_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_PTR  = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;

	logic [1:0]              state;
	logic [2:0]              op_q;
	logic [`HP48_ADDR_W-1:0] addr_q;
	logic [15:0]             data_q;
	logic [2:0]              count_q;
	logic [2:0]              beat_q;
	logic                    xfer;
	logic                    multi_beat;
	logic                    last_beat;

	// requests are taken only while nothing is in flight
	assign req_ready = (state == ST_IDLE);
	assign xfer = link.valid && link.ready;

	// block reads, block writes and fetches are followed by data beats
	assign multi_beat = (op_q == REQ_BLOCK_READ) || (op_q == REQ_BLOCK_WRITE) ||
		(op_q == REQ_FETCH);

	// a count of zero still ends after a single beat
	assign last_beat = ((beat_q + 3'd1) >= count_q);

	always_ff @(posedge strobe) begin
		if (rst) begin
			state <= ST_IDLE;
			beat_q <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						state <= ST_PTR;
						beat_q <= '0;
					end
				end
				ST_PTR: begin
					// pointer load or single command has gone out
					if (xfer) begin
						state <= multi_beat ? ST_DATA : ST_IDLE;
					end
				end
				ST_DATA: begin
					if (xfer) begin
						beat_q <= beat_q + 3'd1;
						if (last_beat) begin
							state <= ST_IDLE;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// the request itself is latched whenever one is accepted
	always_ff @(posedge strobe) begin
		if (req_valid && req_ready) begin
			op_q <= req_op;
			addr_q <= req_address;
			data_q <= req_data;
			// oversized blocks are cut down to the largest the bus allows
			if (req_count > 3'(`HP48_MAX_BLOCK)) begin
				count_q <= 3'(`HP48_MAX_BLOCK);
			end else begin
				count_q <= req_count;
			end
		end
	end

	// the offered command depends only on registered state, so it stays put
	// for as long as the FIFO holds ready low
	always_comb begin
		link.valid = (state != ST_IDLE);
		link.command = BUSCMD_LOAD_DP;
		link.payload.address = addr_q;
		if (state == ST_PTR) begin
			case (op_q)
				REQ_BLOCK_READ, REQ_BLOCK_WRITE: link.command = BUSCMD_LOAD_DP;
				REQ_FETCH: link.command = BUSCMD_LOAD_PC;
				REQ_CONFIGURE: link.command = BUSCMD_CONFIGURE;
				// raw and any unknown op pass the low address nibble as the code
				default: link.command = addr_q[3:0];
			endcase
		end else if (state == ST_DATA) begin
			case (op_q)
				REQ_BLOCK_WRITE: begin
					link.command = BUSCMD_DP_WRITE;
					link.payload.data.pad = '0;
					// nibble 0 sits in the low bits of the request data
					link.payload.data.nibble = data_q[{beat_q[1:0], 2'b00} +: 4];
				end
				REQ_FETCH: link.command = BUSCMD_PC_READ;
				default: link.command = BUSCMD_DP_READ;
			endcase
		end
	end

endmodule

/* rtl/bus_cmd_fifo.sv */
`include "hp48_macros.svh"

// show-ahead buffer for bus commands
// the oldest entry is always presented on the out side, so a word pushed on
// one edge can be taken by the RAM on the very next edge
module bus_cmd_fifo (
	input  logic      strobe,
	input  logic      rst,
	bus_cmd_if.sink   in,
	bus_cmd_if.source out
);
	import hp48_bus_pkg::*;

	localparam int PTR_W = $clog2(`HP48_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`HP48_FIFO_DEPTH + 1);

	logic [3:0]       cmd_mem [0:`HP48_FIFO_DEPTH-1];
	bus_payload_t     pay_mem [0:`HP48_FIFO_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == CNT_W'(`HP48_FIFO_DEPTH));

	// a full buffer still takes a word when the head leaves on the same edge
	assign in.ready = !full || out.ready;
	assign push = in.valid && in.ready;
	assign pop = out.valid && out.ready;

	assign out.valid = (count != '0);
	assign out.command = cmd_mem[rd_ptr];
	assign out.payload = pay_mem[rd_ptr];

	always_ff @(posedge strobe) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`HP48_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`HP48_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves when exactly one side transfers
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge strobe) begin
		if (push) begin
			cmd_mem[wr_ptr] <= in.command;
			pay_mem[wr_ptr] <= in.payload;
		end
	end

endmodule

/* rtl/hp48_io_ram.sv */
`include "hp48_macros.svh"

// memory-mapped I/O RAM of 64 nibbles on the calculator bus
// the array stays invisible until a CONFIGURE gives it a base address, and
// reads and writes then hit only inside the window that starts at the base
module hp48_io_ram (
	input  logic    strobe,
	input  logic    rst,
	bus_cmd_if.sink link,
	output logic    rd_valid,
	output logic    [3:0] rd_nibble,
	output logic    rd_status,
	input  logic    rd_ready,
	output logic    active,
	output logic    error,
	input  logic    daisy_in,
	output logic    daisy_out
);
	import hp48_bus_pkg::*;
	import hp48_req_pkg::*;

	localparam int IDX_W = $clog2(`HP48_IO_RAM_LEN);

	logic                    configured;
	logic [`HP48_ADDR_W-1:0] base_addr;
	logic [`HP48_ADDR_W-1:0] pc_ptr;
	logic [`HP48_ADDR_W-1:0] dp_ptr;
	logic [3:0]              mem [0:`HP48_IO_RAM_LEN-1];
	logic [`HP48_ADDR_W-1:0] pc_off;
	logic [`HP48_ADDR_W-1:0] dp_off;
	logic                    pc_hit;
	logic                    dp_hit;
	logic                    xfer;

	// the next device on the daisy chain may configure once this one has
	assign daisy_out = configured;

	// a pending read result blocks further commands until the host takes it
	assign link.ready = !rd_valid;
	assign xfer = link.valid && link.ready;

	// offsets are taken against the base, so a window near the top of the
	// address space does not wrap around
	assign pc_off = pc_ptr - base_addr;
	assign dp_off = dp_ptr - base_addr;
	assign pc_hit = configured && (pc_ptr >= base_addr) &&
		(pc_off < `HP48_ADDR_W'(`HP48_IO_RAM_LEN));
	assign dp_hit = configured && (dp_ptr >= base_addr) &&
		(dp_off < `HP48_ADDR_W'(`HP48_IO_RAM_LEN));

	// tells the bus that this device answers the command now at the sink
	always_comb begin
		active = 1'b0;
		if (link.valid) begin
			case (link.command)
				BUSCMD_PC_READ: active = pc_hit;
				BUSCMD_DP_READ, BUSCMD_DP_WRITE: active = dp_hit;
				default: active = 1'b0;
			endcase
		end
	end

	always_ff @(posedge strobe) begin
		if (rst) begin
			configured <= 1'b0;
			base_addr <= '0;
			pc_ptr <= '0;
			dp_ptr <= '0;
			rd_valid <= 1'b0;
			error <= 1'b0;
		end else begin
			if (rd_valid && rd_ready) begin
				rd_valid <= 1'b0;
			end
			// xfer only happens with rd_valid low, so the set below never
			// collides with the clear above
			if (xfer) begin
				case (link.command)
					BUSCMD_PC_READ: begin
						rd_valid <= 1'b1;
						pc_ptr <= pc_ptr + 1'b1;
					end
					BUSCMD_DP_READ: begin
						rd_valid <= 1'b1;
						dp_ptr <= dp_ptr + 1'b1;
					end
					BUSCMD_DP_WRITE: dp_ptr <= dp_ptr + 1'b1;
					BUSCMD_LOAD_PC: pc_ptr <= link.payload.address;
					BUSCMD_LOAD_DP: dp_ptr <= link.payload.address;
					BUSCMD_CONFIGURE: begin
						// only the first device in line that is still unconfigured takes it
						if (!configured && daisy_in) begin
							base_addr <= link.payload.address;
							configured <= 1'b1;
						end else begin
							error <= 1'b1;
						end
					end
					// anything else is unimplemented here and the flag sticks
					default: error <= 1'b1;
				endcase
			end
		end
	end

	// the array takes writes and returns read data, and a miss reads as zero
	always_ff @(posedge strobe) begin
		if (xfer) begin
			case (link.command)
				BUSCMD_PC_READ: begin
					rd_nibble <= pc_hit ? mem[pc_off[IDX_W-1:0]] : 4'h0;
					rd_status <= pc_hit ? RD_HIT : RD_MISS;
				end
				BUSCMD_DP_READ: begin
					rd_nibble <= dp_hit ? mem[dp_off[IDX_W-1:0]] : 4'h0;
					rd_status <= dp_hit ? RD_HIT : RD_MISS;
				end
				BUSCMD_DP_WRITE: begin
					if (dp_hit) begin
						mem[dp_off[IDX_W-1:0]] <= link.payload.data.nibble;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* rtl/hp48_io_subsys.sv */
`include "hp48_macros.svh"

// one I/O RAM device with its request front end
// host requests go through the sequencer, wait in the command FIFO and are
// executed by the RAM, which hands read nibbles back to the host in order
module hp48_io_subsys (
	input  logic                    strobe,
	input  logic                    rst,
	input  logic                    req_valid,
	input  logic [2:0]              req_op,
	input  logic [`HP48_ADDR_W-1:0] req_address,
	input  logic [15:0]             req_data,
	input  logic [2:0]              req_count,
	output logic                    req_ready,
	output logic                    rd_valid,
	output logic [3:0]              rd_nibble,
	output logic                    rd_status,
	input  logic                    rd_ready,
	output logic                    error,
	output logic                    active,
	input  logic                    daisy_in,
	output logic                    daisy_out
);

	// sequencer to FIFO
	bus_cmd_if seq_link ();
	// FIFO to RAM
	bus_cmd_if ram_link ();

	bus_sequencer u_sequencer (
		.strobe      (strobe),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_address (req_address),
		.req_data    (req_data),
		.req_count   (req_count),
		.req_ready   (req_ready),
		.link        (seq_link)
	);

	bus_cmd_fifo u_fifo (
		.strobe (strobe),
		.rst    (rst),
		.in     (seq_link),
		.out    (ram_link)
	);

	hp48_io_ram u_io_ram (
		.strobe    (strobe),
		.rst       (rst),
		.link      (ram_link),
		.rd_valid  (rd_valid),
		.rd_nibble (rd_nibble),
		.rd_status (rd_status),
		.rd_ready  (rd_ready),
		.active    (active),
		.error     (error),
		.daisy_in  (daisy_in),
		.daisy_out (daisy_out)
	);

endmodule

/* bench/tb_hp48_io_subsys.sv */
`include "hp48_macros.svh"

// testbench for the I/O RAM subsystem
// requests come from a table and the host takes read results under random
// back-pressure, while a reference model predicts every read and flag
module tb_hp48_io_subsys;
	import hp48_bus_pkg::*;
	import hp48_req_pkg::*;

	// each row holds op, address, data, count, settle and expected error
	// a row with settle set waits for the design to drain before flags are checked
	localparam int ROW_W = 3 + `HP48_ADDR_W + 16 + 3 + 1 + 1;
	localparam int ROWS = 18;
	localparam int CYCLE_LIMIT = 40 * ROWS + 200;
	localparam int IDX_W = $clog2(`HP48_IO_RAM_LEN);

	localparam logic [ROW_W-1:0] REQ_TABLE [0:ROWS-1] = '{
		{REQ_BLOCK_READ,  20'h00100, 16'h0000, 3'd4, 1'b1, 1'b0},
		{REQ_CONFIGURE,   20'h00100, 16'h0000, 3'd1, 1'b1, 1'b0},
		{REQ_BLOCK_WRITE, 20'h00104, 16'hc3a5, 3'd4, 1'b1, 1'b0},
		{REQ_BLOCK_READ,  20'h00104, 16'h0000, 3'd4, 1'b1, 1'b0},
		{REQ_FETCH,       20'h00105, 16'h0000, 3'd3, 1'b1, 1'b0},
		{REQ_FETCH,       20'h00140, 16'h0000, 3'd2, 1'b1, 1'b0},
		{REQ_BLOCK_WRITE, 20'h0013e, 16'h0f96, 3'd4, 1'b1, 1'b0},
		{REQ_BLOCK_READ,  20'h0013e, 16'h0000, 3'd4, 1'b1, 1'b0},
		{REQ_CONFIGURE,   20'h00200, 16'h0000, 3'd1, 1'b1, 1'b1},
		{REQ_RAW,         20'h0000f, 16'h0000, 3'd1, 1'b1, 1'b1},
		{REQ_BLOCK_WRITE, 20'h00110, 16'h1234, 3'd4, 1'b0, 1'b1},
		{REQ_BLOCK_READ,  20'h00110, 16'h0000, 3'd4, 1'b0, 1'b1},
		{REQ_FETCH,       20'h00104, 16'h0000, 3'd4, 1'b0, 1'b1},
		{REQ_BLOCK_READ,  20'h00104, 16'h0000, 3'd2, 1'b0, 1'b1},
		{REQ_RAW,         20'h00001, 16'h0000, 3'd1, 1'b0, 1'b1},
		{REQ_FETCH,       20'h00112, 16'h0000, 3'd2, 1'b0, 1'b1},
		{REQ_BLOCK_READ,  20'h00ff0, 16'h0000, 3'd4, 1'b0, 1'b1},
		{REQ_BLOCK_READ,  20'h0013e, 16'h0000, 3'd2, 1'b1, 1'b1}
	};

	logic                    strobe;
	logic                    rst;
	logic                    req_valid;
	logic [2:0]              req_op;
	logic [`HP48_ADDR_W-1:0] req_address;
	logic [15:0]             req_data;
	logic [2:0]              req_count;
	logic                    req_ready;
	logic                    rd_valid;
	logic [3:0]              rd_nibble;
	logic                    rd_status;
	logic                    rd_ready;
	logic                    error;
	logic                    active;
	logic                    daisy_in;
	logic                    daisy_out;

	// reference state that follows the same rules as the I/O RAM
	logic [3:0]              model_mem [0:`HP48_IO_RAM_LEN-1];
	logic                    model_configured;
	logic                    model_error;
	logic [`HP48_ADDR_W-1:0] model_base;
	logic [`HP48_ADDR_W-1:0] model_pc;
	logic [`HP48_ADDR_W-1:0] model_dp;
	// predicted read results in bus order with the status above the nibble
	logic [4:0]              expected_reads [$];
	// predicted active level for each bus command in bus order
	logic                    expected_active [$];
	int                      check_errors;
	int                      other_errors;
	int                      cycles;
	int                      seed;

	hp48_io_subsys dut (
		.strobe      (strobe),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_address (req_address),
		.req_data    (req_data),
		.req_count   (req_count),
		.req_ready   (req_ready),
		.rd_valid    (rd_valid),
		.rd_nibble   (rd_nibble),
		.rd_status   (rd_status),
		.rd_ready    (rd_ready),
		.error       (error),
		.active      (active),
		.daisy_in    (daisy_in),
		.daisy_out   (daisy_out)
	);

	initial begin
		strobe = 1'b0;
		forever #50 strobe = ~strobe;
	end

	task automatic check_nibble(input logic [3:0] got_nibble, input logic got_status,
		input logic [3:0] exp_nibble, input logic exp_status);
		if (got_nibble !== exp_nibble || got_status !== exp_status) begin
			check_errors++;
			$display("CHECK FAILED at %0t: read nibble %h status %b, expected nibble %h status %b",
				$time, got_nibble, got_status, exp_nibble, exp_status);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	// a pointer hits when the device is configured and the pointer lies in
	// the 64 nibbles from the base upward
	function automatic logic model_hit(input logic [`HP48_ADDR_W-1:0] ptr);
		return model_configured && (int'(ptr) >= int'(model_base)) &&
			(int'(ptr) < int'(model_base) + `HP48_IO_RAM_LEN);
	endfunction

	task automatic model_read(input logic [`HP48_ADDR_W-1:0] ptr);
		logic [`HP48_ADDR_W-1:0] offset;
		offset = ptr - model_base;
		if (model_hit(ptr)) begin
			expected_reads.push_back({RD_HIT, model_mem[offset[IDX_W-1:0]]});
		end else begin
			expected_reads.push_back({RD_MISS, 4'h0});
		end
	endtask

	// one bus command as the RAM executes it
	task automatic model_command(input logic [3:0] cmd, input logic [`HP48_ADDR_W-1:0] word);
		logic [`HP48_ADDR_W-1:0] offset;
		logic                    beat_active;
		offset = model_dp - model_base;
		// only a data beat that lands in the window makes the RAM answer
		beat_active = 1'b0;
		case (cmd)
			BUSCMD_PC_READ: begin
				beat_active = model_hit(model_pc);
				model_read(model_pc);
				model_pc = model_pc + `HP48_ADDR_W'(1);
			end
			BUSCMD_DP_READ: begin
				beat_active = model_hit(model_dp);
				model_read(model_dp);
				model_dp = model_dp + `HP48_ADDR_W'(1);
			end
			BUSCMD_DP_WRITE: begin
				beat_active = model_hit(model_dp);
				// writes outside the window are dropped, but the pointer still moves
				if (beat_active) begin
					model_mem[offset[IDX_W-1:0]] = word[3:0];
				end
				model_dp = model_dp + `HP48_ADDR_W'(1);
			end
			BUSCMD_LOAD_PC: model_pc = word;
			BUSCMD_LOAD_DP: model_dp = word;
			BUSCMD_CONFIGURE: begin
				if (!model_configured && daisy_in) begin
					model_base = word;
					model_configured = 1'b1;
				end else begin
					model_error = 1'b1;
				end
			end
			default: model_error = 1'b1;
		endcase
		expected_active.push_back(beat_active);
	endtask

	// a host request expands into a pointer load or single command, then data beats
	task automatic model_request(input logic [2:0] op, input logic [`HP48_ADDR_W-1:0] addr,
		input logic [15:0] data, input logic [2:0] count);
		int beat;
		case (op)
			REQ_BLOCK_READ, REQ_BLOCK_WRITE: model_command(BUSCMD_LOAD_DP, addr);
			REQ_FETCH: model_command(BUSCMD_LOAD_PC, addr);
			REQ_CONFIGURE: model_command(BUSCMD_CONFIGURE, addr);
			default: model_command(addr[3:0], addr);
		endcase
		for (beat = 0; beat < int'(count); beat++) begin
			case (op)
				REQ_BLOCK_READ: model_command(BUSCMD_DP_READ, '0);
				REQ_BLOCK_WRITE: model_command(BUSCMD_DP_WRITE, `HP48_ADDR_W'(data[beat*4 +: 4]));
				REQ_FETCH: model_command(BUSCMD_PC_READ, '0);
				default: ;
			endcase
		end
	endtask

	// idle means no request in flight, an empty FIFO and every read delivered
	task automatic wait_idle();
		@(negedge strobe);
		while (!req_ready || dut.u_fifo.count != '0 || rd_valid || expected_reads.size() != 0) begin
			@(negedge strobe);
		end
	endtask

	// the host takes read results at random
	initial begin
		logic [31:0] rnd;
		seed = 32'h2095f4c5;
		rd_ready = 1'b0;
		forever begin
			@(posedge strobe);
			rnd = $random(seed);
			rd_ready <= rnd[0];
		end
	end

	// a result transfers on the next edge when valid and ready are both high here
	initial begin
		logic [4:0] expected;
		forever begin
			@(negedge strobe);
			if (!rst && rd_valid && rd_ready) begin
				if (expected_reads.size() == 0) begin
					other_errors++;
					$display("a read result arrived at time %0t when none was outstanding", $time);
				end else begin
					expected = expected_reads.pop_front();
					check_nibble(rd_nibble, rd_status, expected[3:0], expected[4]);
				end
			end
		end
	end

	// active follows the command waiting at the RAM, and that command leaves
	// on the next edge unless a read result is still pending
	initial begin
		forever begin
			@(negedge strobe);
			if (!rst) begin
				if (dut.u_fifo.count == '0) begin
					check_flag("active", active, 1'b0);
				end else if (expected_active.size() == 0) begin
					other_errors++;
					$display("a bus command reached the RAM at time %0t when none was expected",
						$time);
				end else begin
					check_flag("active", active, expected_active[0]);
					if (!rd_valid) begin
						expected_active.delete(0);
					end
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge strobe);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [2:0]              op;
		logic [`HP48_ADDR_W-1:0] addr;
		logic [15:0]             data;
		logic [2:0]              count;
		logic                    settle;
		logic                    exp_error;
		int                      row;
		rst = 1'b1;
		req_valid = 1'b0;
		req_op = '0;
		req_address = '0;
		req_data = '0;
		req_count = '0;
		daisy_in = 1'b1;
		check_errors = 0;
		other_errors = 0;
		model_configured = 1'b0;
		model_error = 1'b0;
		model_base = '0;
		model_pc = '0;
		model_dp = '0;
		repeat (3) @(posedge strobe);
		rst <= 1'b0;
		for (row = 0; row < ROWS; row++) begin
			{op, addr, data, count, settle, exp_error} = REQ_TABLE[row];
			@(posedge strobe);
			req_valid <= 1'b1;
			req_op <= op;
			req_address <= addr;
			req_data <= data;
			req_count <= count;
			// req_ready only moves on a rising edge, so its value here holds at the next one
			@(negedge strobe);
			while (!req_ready) begin
				@(negedge strobe);
			end
			@(posedge strobe);
			req_valid <= 1'b0;
			model_request(op, addr, data, count);
			if (settle) begin
				wait_idle();
				check_flag("error", error, exp_error);
				check_flag("daisy_out", daisy_out, model_configured);
				if (model_error !== exp_error) begin
					other_errors++;
					$display("row %0d expects error %b but the reference model gives %b",
						row, exp_error, model_error);
				end
			end
		end
		if (expected_active.size() != 0) begin
			other_errors++;
			$display("%0d predicted bus commands never reached the RAM", expected_active.size());
		end
		$display("errors: %0d check failures, %0d other failures", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+rtl
rtl/hp48_bus_pkg.sv
rtl/hp48_req_pkg.sv
rtl/bus_cmd_if.sv
rtl/bus_sequencer.sv
rtl/bus_cmd_fifo.sv
rtl/hp48_io_ram.sv
rtl/hp48_io_subsys.sv
bench/tb_hp48_io_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_hp48_io_subsys -o tb_hp48_io_subsys
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_hp48_io_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
fi
exit 1
